// File: hdl/ptw_pkg.sv
`default_nettype none

package ptw_pkg;

    // flag positions in a page table entry
    localparam int pte_v_bit = 0;
    localparam int pte_r_bit = 1;
    localparam int pte_w_bit = 2;
    localparam int pte_x_bit = 3;

    localparam int ppn_lsb   = 10;
    localparam int ppn_width = 44;

    localparam int vpn_width         = 9;  // index bits per level
    localparam int page_offset_width = 12;

    localparam int beats_per_line = 8;     // 64-byte line, 64-bit beats

    typedef enum logic [2:0] {
        idle,
        arb,
        req,
        wait_resp,
        beats,
        step,
        done
    } walk_state_t;

endpackage

`default_nettype wire

// File: hdl/pte_decode.sv
`timescale 1ns/10ps
`default_nettype none

module pte_decode
    import ptw_pkg::*;
#(
    parameter int levels = 3
)
(
    input  logic [$clog2(levels)-1:0]                     level,
    input  logic [page_offset_width+levels*vpn_width-1:0] virt_addr,
    input  logic [ppn_width-1:0]                          root_ppn,
    input  logic [63:0]                                   pte,
    output logic [ppn_width+page_offset_width-1:0]        next_entry_addr,
    output logic                                          is_leaf,
    output logic                                          fault,
    output logic [ppn_width+page_offset_width-1:0]        leaf_phys_addr
);
    localparam int pa_width = ppn_width + page_offset_width;

    logic [ppn_width-1:0] pte_ppn;
    logic [ppn_width-1:0] base_ppn;
    logic [vpn_width-1:0] vpn_sel;
    logic                 pte_v;
    logic                 pte_r;
    logic                 pte_w;
    logic                 pte_x;
    logic                 last_level;

    assign pte_ppn = pte[ppn_lsb +: ppn_width];
    assign pte_v   = pte[pte_v_bit];
    assign pte_r   = pte[pte_r_bit];
    assign pte_w   = pte[pte_w_bit];
    assign pte_x   = pte[pte_x_bit];

    assign last_level = (int'(level) == levels - 1);

    // level 0 picks the top index field of the virtual address
    assign vpn_sel = virt_addr[page_offset_width + (levels - 1 - int'(level)) * vpn_width
                               +: vpn_width];

    assign base_ppn = (level == '0) ? root_ppn : pte_ppn;  // root table or next table

    assign next_entry_addr = {base_ppn, {page_offset_width{1'b0}}}
                           + pa_width'({vpn_sel, 3'b000});  // 8-byte entries

    assign is_leaf = pte_r | pte_x;

    always_comb
    begin
        fault = 1'b0;
        if (!pte_v)
        begin
            fault = 1'b1;
        end
        else if (pte_w && !pte_r)
        begin
            fault = 1'b1;  // write-only is reserved
        end
        else if (!is_leaf && last_level)
        begin
            fault = 1'b1;  // no table below the last level
        end
    end

    // superpage leaves keep the lower index fields of the virtual address
    always_comb
    begin
        leaf_phys_addr = {pte_ppn, virt_addr[page_offset_width-1:0]};
        for (int i = 0; i < levels - 1; i++)
        begin
            if (i < levels - 1 - int'(level))
            begin
                leaf_phys_addr[page_offset_width + i * vpn_width +: vpn_width] =
                    virt_addr[page_offset_width + i * vpn_width +: vpn_width];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ptw_walk_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ptw_walk_ctrl
    import ptw_pkg::*;
#(
    parameter int levels = 3
)
(
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          walk_start,
    input  logic [page_offset_width+levels*vpn_width-1:0] virt_addr,
    input  logic [ppn_width-1:0]                          root_ppn,
    input  logic                                          abtr_grant,
    output logic                                          abtr_req,
    output logic                                          bus_reqcyc,
    output logic [ppn_width+page_offset_width-1:0]        bus_req_addr,
    input  logic                                          bus_respcyc,
    input  logic [63:0]                                   bus_resp,
    output logic                                          bus_respack,
    output logic                                          walk_done,
    output logic [ppn_width+page_offset_width-1:0]        walk_phys_addr,
    output logic                                          walk_perm_r,
    output logic                                          walk_perm_w,
    output logic                                          walk_perm_x,
    output logic                                          walk_fault
);
    localparam int va_width  = page_offset_width + levels * vpn_width;
    localparam int pa_width  = ppn_width + page_offset_width;
    localparam int lvl_width = $clog2(levels);
    localparam int cnt_width = $clog2(beats_per_line);

    walk_state_t state;
    walk_state_t next_state;

    logic [lvl_width-1:0] level;
    logic [cnt_width-1:0] beat_cnt;
    logic [va_width-1:0]  va_q;
    logic [pa_width-1:0]  entry_addr;
    logic [63:0]          kept_pte;
    logic                 beat_taken;
    logic                 last_beat;
    logic                 finish;

    logic [pa_width-1:0]  next_entry_addr;
    logic [pa_width-1:0]  leaf_phys_addr;
    logic                 is_leaf;
    logic                 fault;

    pte_decode #(
        .levels(levels)
    ) pte_decode_inst (
        .level          (level),
        .virt_addr      (va_q),
        .root_ppn       (root_ppn),
        .pte            (kept_pte),
        .next_entry_addr(next_entry_addr),
        .is_leaf        (is_leaf),
        .fault          (fault),
        .leaf_phys_addr (leaf_phys_addr)
    );

    // first beat may already come while waiting
    assign beat_taken = bus_respcyc && (state == wait_resp || state == beats);
    assign last_beat  = beat_taken && (beat_cnt == cnt_width'(beats_per_line - 1));
    assign finish     = is_leaf || fault;

    always_comb
    begin
        next_state = state;
        case (state)
            idle:      next_state = walk_start ? arb : idle;
            arb:       next_state = abtr_grant ? req : arb;
            req:       next_state = wait_resp;
            wait_resp: next_state = beat_taken ? beats : wait_resp;
            beats:     next_state = last_beat ? step : beats;
            step:      next_state = finish ? done : arb;  // next level re-arbitrates
            done:      next_state = idle;
            default:   next_state = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= idle;
            level    <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == idle && walk_start)
            begin
                level <= '0;
            end
            if (state == step && !finish)
            begin
                level <= level + 1'b1;  // descend
            end
            if (state == req)
            begin
                beat_cnt <= '0;
            end
            else if (beat_taken)
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && walk_start)
        begin
            va_q <= virt_addr;
        end
        if (state == arb && abtr_grant)
        begin
            entry_addr <= next_entry_addr;  // address for this level
        end
        if (beat_taken && beat_cnt == entry_addr[5:3])
        begin
            kept_pte <= bus_resp;
        end
        if (state == step && finish)
        begin
            walk_phys_addr <= fault ? '0 : leaf_phys_addr;
            walk_perm_r    <= !fault && kept_pte[pte_r_bit];
            walk_perm_w    <= !fault && kept_pte[pte_w_bit];
            walk_perm_x    <= !fault && kept_pte[pte_x_bit];
            walk_fault     <= fault;
        end
    end

    // bus held from grant through the last beat
    assign abtr_req     = (state == arb) || (state == req) || (state == wait_resp)
                       || (state == beats);
    assign bus_reqcyc   = (state == req);
    assign bus_req_addr = {entry_addr[pa_width-1:6], 6'b000000};  // line aligned
    assign bus_respack  = beat_taken;
    assign walk_done    = (state == done);

endmodule

`default_nettype wire

// File: hdl/ptw_result.sv
`timescale 1ns/10ps
`default_nettype none

module ptw_result
    import ptw_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   trans_req,
    input  logic                                   walk_done,
    input  logic [ppn_width+page_offset_width-1:0] walk_phys_addr,
    input  logic                                   walk_perm_r,
    input  logic                                   walk_perm_w,
    input  logic                                   walk_perm_x,
    input  logic                                   walk_fault,
    output logic                                   walk_start,
    output logic                                   trans_ack,
    output logic [ppn_width+page_offset_width-1:0] phys_addr,
    output logic                                   perm_r,
    output logic                                   perm_w,
    output logic                                   perm_x,
    output logic                                   page_fault
);
    localparam logic [1:0] hs_idle    = 2'd0;
    localparam logic [1:0] hs_walking = 2'd1;
    localparam logic [1:0] hs_acking  = 2'd2;
    localparam logic [1:0] hs_release = 2'd3;

    logic [1:0] state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= hs_idle;
            walk_start <= 1'b0;
        end
        else
        begin
            walk_start <= (state == hs_idle) && trans_req;  // single pulse
            case (state)
                hs_idle:    if (trans_req) state <= hs_walking;
                hs_walking: if (walk_done) state <= hs_acking;
                hs_acking:  if (!trans_req) state <= hs_release;  // client let go
                hs_release: state <= hs_idle;
                default:    state <= hs_idle;
            endcase
        end
    end

    // held while ack is up
    always_ff @(posedge clk)
    begin
        if (walk_done)
        begin
            phys_addr  <= walk_phys_addr;
            perm_r     <= walk_perm_r;
            perm_w     <= walk_perm_w;
            perm_x     <= walk_perm_x;
            page_fault <= walk_fault;
        end
    end

    assign trans_ack = (state == hs_acking);

endmodule

`default_nettype wire

// File: hdl/ptw_top.sv
`timescale 1ns/10ps
`default_nettype none

module ptw_top
    import ptw_pkg::*;
#(
    parameter int levels = 3  // 3 for Sv39, 4 for Sv48
)
(
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          trans_req,
    input  logic [page_offset_width+levels*vpn_width-1:0] virt_addr,
    input  logic [ppn_width-1:0]                          root_ppn,
    output logic                                          trans_ack,
    output logic [ppn_width+page_offset_width-1:0]        phys_addr,
    output logic                                          perm_r,
    output logic                                          perm_w,
    output logic                                          perm_x,
    output logic                                          page_fault,
    output logic                                          abtr_req,
    input  logic                                          abtr_grant,
    output logic                                          bus_reqcyc,
    output logic [ppn_width+page_offset_width-1:0]        bus_req_addr,
    input  logic                                          bus_respcyc,
    input  logic [63:0]                                   bus_resp,
    output logic                                          bus_respack
);
    logic                                   walk_start;
    logic                                   walk_done;
    logic [ppn_width+page_offset_width-1:0] walk_phys_addr;
    logic                                   walk_perm_r;
    logic                                   walk_perm_w;
    logic                                   walk_perm_x;
    logic                                   walk_fault;

    ptw_walk_ctrl #(
        .levels(levels)
    ) ptw_walk_ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .walk_start    (walk_start),
        .virt_addr     (virt_addr),
        .root_ppn      (root_ppn),
        .abtr_grant    (abtr_grant),
        .abtr_req      (abtr_req),
        .bus_reqcyc    (bus_reqcyc),
        .bus_req_addr  (bus_req_addr),
        .bus_respcyc   (bus_respcyc),
        .bus_resp      (bus_resp),
        .bus_respack   (bus_respack),
        .walk_done     (walk_done),
        .walk_phys_addr(walk_phys_addr),
        .walk_perm_r   (walk_perm_r),
        .walk_perm_w   (walk_perm_w),
        .walk_perm_x   (walk_perm_x),
        .walk_fault    (walk_fault)
    );

    ptw_result ptw_result_inst (
        .clk           (clk),
        .reset         (reset),
        .trans_req     (trans_req),
        .walk_done     (walk_done),
        .walk_phys_addr(walk_phys_addr),
        .walk_perm_r   (walk_perm_r),
        .walk_perm_w   (walk_perm_w),
        .walk_perm_x   (walk_perm_x),
        .walk_fault    (walk_fault),
        .walk_start    (walk_start),
        .trans_ack     (trans_ack),
        .phys_addr     (phys_addr),
        .perm_r        (perm_r),
        .perm_w        (perm_w),
        .perm_x        (perm_x),
        .page_fault    (page_fault)
    );

endmodule

`default_nettype wire

// File: tests/ptw_props.sv
`timescale 1ns/10ps
`default_nettype none

module ptw_props
    import ptw_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic trans_req,
    input logic trans_ack,
    input logic abtr_req,
    input logic abtr_grant,
    input logic bus_reqcyc,
    input logic bus_respcyc,
    input logic bus_respack
);
    int fail_count = 0;  // failures so far

    req_held: assert property (@(posedge clk) disable iff (reset)
        abtr_req && !abtr_grant |=> abtr_req)
    else
    begin
        $error("abtr_req dropped before abtr_grant");
        fail_count = fail_count + 1;
    end

    reqcyc_granted: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc |-> abtr_grant)
    else
    begin
        $error("bus_reqcyc without abtr_grant");
        fail_count = fail_count + 1;
    end

    // every presented beat is taken, and nothing else is acked
    respack_with_beat: assert property (@(posedge clk) disable iff (reset)
        bus_respack == bus_respcyc)
    else
    begin
        $error("bus_respack and bus_respcyc disagree");
        fail_count = fail_count + 1;
    end

    // ack only drops once the client has let go
    ack_held: assert property (@(posedge clk) disable iff (reset)
        trans_ack && trans_req |=> trans_ack)
    else
    begin
        $error("trans_ack fell while trans_req was high");
        fail_count = fail_count + 1;
    end

endmodule

`default_nettype wire

// File: tests/tb_ptw_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ptw_top;
    localparam int levels   = 3;
    localparam int va_width = 39;
    localparam int pa_width = 56;

    localparam logic [43:0] root_tbl = 44'h100;
    localparam logic [43:0] t1a      = 44'h101;
    localparam logic [43:0] t2a      = 44'h102;
    localparam logic [43:0] t1b      = 44'h104;
    localparam logic [43:0] t2b      = 44'h105;

    typedef struct packed {
        logic [va_width-1:0] va;
        logic [pa_width-1:0] pa;
        logic                r;
        logic                w;
        logic                x;
        logic                fault;
        logic [3:0]          hold;  // extra cycles with trans_req up
    } row_t;

    logic                clk;
    logic                reset;
    logic                trans_req;
    logic [va_width-1:0] virt_addr;
    logic [43:0]         root_ppn;
    logic                trans_ack;
    logic [pa_width-1:0] phys_addr;
    logic                perm_r;
    logic                perm_w;
    logic                perm_x;
    logic                page_fault;
    logic                abtr_req;
    logic                abtr_grant;
    logic                bus_reqcyc;
    logic [pa_width-1:0] bus_req_addr;
    logic                bus_respcyc;
    logic [63:0]         bus_resp;
    logic                bus_respack;

    logic [63:0]         mem [logic [pa_width-1:0]];  // by byte address
    row_t                rows [$];
    logic [31:0]         lfsr;
    int                  cycle_count = 0;
    int                  timeout_cycles;
    logic                grant_armed;
    int                  grant_wait;
    logic                resp_active;
    logic                gap_prev;
    int                  resp_idx;
    logic [pa_width-1:0] resp_base;

    ptw_top #(
        .levels(levels)
    ) ptw_top_inst (
        .clk         (clk),
        .reset       (reset),
        .trans_req   (trans_req),
        .virt_addr   (virt_addr),
        .root_ppn    (root_ppn),
        .trans_ack   (trans_ack),
        .phys_addr   (phys_addr),
        .perm_r      (perm_r),
        .perm_w      (perm_w),
        .perm_x      (perm_x),
        .page_fault  (page_fault),
        .abtr_req    (abtr_req),
        .abtr_grant  (abtr_grant),
        .bus_reqcyc  (bus_reqcyc),
        .bus_req_addr(bus_req_addr),
        .bus_respcyc (bus_respcyc),
        .bus_resp    (bus_resp),
        .bus_respack (bus_respack)
    );

    bind ptw_top ptw_props ptw_props_inst (
        .clk        (clk),
        .reset      (reset),
        .trans_req  (trans_req),
        .trans_ack  (trans_ack),
        .abtr_req   (abtr_req),
        .abtr_grant (abtr_grant),
        .bus_reqcyc (bus_reqcyc),
        .bus_respcyc(bus_respcyc),
        .bus_respack(bus_respack)
    );

    always #20 clk = ~clk;

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
        begin
            lfsr = lfsr ^ 32'ha3000000;
        end
        return out;
    endfunction

    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val = (val << 1) | int'(lfsr_bit());
        end
        return val;
    endfunction

    function automatic logic [63:0] pte(input logic [43:0] ppn, input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};  // flags are x w r v from bit 3 down
    endfunction

    function automatic logic [pa_width-1:0] entry(input logic [43:0] tbl, input logic [8:0] idx);
        return {tbl, idx, 3'b000};
    endfunction

    function automatic logic [va_width-1:0] va_of(input logic [8:0] vpn2, input logic [8:0] vpn1,
                                                  input logic [8:0] vpn0, input logic [11:0] off);
        return {vpn2, vpn1, vpn0, off};
    endfunction

    // unwritten words look like invalid entries tagged with their address
    function automatic logic [63:0] read_word(input logic [pa_width-1:0] addr);
        if (mem.exists(addr))
        begin
            return mem[addr];
        end
        return {8'hc3, addr};
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic load_page_tables();
        mem[entry(root_tbl, 9'd1)]  = pte(t1a, 8'h01);
        mem[entry(t1a, 9'd2)]       = pte(t2a, 8'h01);
        mem[entry(t2a, 9'd3)]       = pte(44'h12345, 8'h07);
        mem[entry(t1a, 9'd4)]       = pte(44'h40200, 8'h0b);  // 2 MiB leaf
        mem[entry(root_tbl, 9'd5)]  = pte(44'h80000, 8'h0f);  // 1 GiB leaf
        mem[entry(t2a, 9'd6)]       = pte(44'h77777, 8'h00);
        mem[entry(t1a, 9'd7)]       = pte(44'h05555, 8'h05);  // write only
        mem[entry(t2a, 9'd0)]       = pte(44'h00103, 8'h01);  // pointer at last level
        mem[entry(root_tbl, 9'd0)]  = pte(t1b, 8'h01);
        mem[entry(t1b, 9'h01f)]     = pte(t2b, 8'h01);
        mem[entry(t2b, 9'h105)]     = pte(44'h0abcd, 8'h09);
        mem[entry(t2b, 9'h10c)]     = pte(44'hfedcba987, 8'h03);
        mem[entry(root_tbl, 9'd3)]  = pte(44'h00999, 8'h0e);  // v clear
    endtask

    task automatic add_row(input logic [va_width-1:0] va, input logic [pa_width-1:0] pa,
                           input logic r, input logic w, input logic x, input logic f,
                           input int hold);
        row_t row;
        row.va    = va;
        row.pa    = pa;
        row.r     = r;
        row.w     = w;
        row.x     = x;
        row.fault = f;
        row.hold  = 4'(hold);
        rows.push_back(row);
    endtask

    task automatic load_rows();
        add_row(va_of(9'd1, 9'd2, 9'd3, 12'h123), 56'h12345123, 1, 1, 0, 0, 0);
        add_row(va_of(9'd1, 9'd4, 9'h1ab, 12'h456), 56'h403ab456, 1, 0, 1, 0, 4);
        add_row(va_of(9'd5, 9'h0c7, 9'h055, 12'hfff), 56'h98e55fff, 1, 1, 1, 0, 0);
        add_row(va_of(9'd1, 9'd2, 9'd6, 12'h010), 56'h0, 0, 0, 0, 1, 6);
        add_row(va_of(9'd1, 9'd7, 9'd0, 12'h000), 56'h0, 0, 0, 0, 1, 0);
        add_row(va_of(9'd1, 9'd2, 9'd0, 12'h800), 56'h0, 0, 0, 0, 1, 2);
        add_row(va_of(9'd0, 9'h01f, 9'h105, 12'habc), 56'habcdabc, 0, 0, 1, 0, 0);
        add_row(va_of(9'd0, 9'h01f, 9'h10c, 12'h001), 56'hfedcba987001, 1, 0, 0, 0, 3);
        add_row(va_of(9'd3, 9'h033, 9'h044, 12'h000), 56'h0, 0, 0, 0, 1, 0);
        add_row(va_of(9'd1, 9'd2, 9'd3, 12'hfed), 56'h12345fed, 1, 1, 0, 0, 0);
    endtask

    task automatic check_results(input row_t row);
        check_value("phys_addr", 64'(phys_addr), 64'(row.pa));
        check_value("perm_r", 64'(perm_r), 64'(row.r));
        check_value("perm_w", 64'(perm_w), 64'(row.w));
        check_value("perm_x", 64'(perm_x), 64'(row.x));
        check_value("page_fault", 64'(page_fault), 64'(row.fault));
    endtask

    // one four-phase exchange
    task automatic run_row(input row_t row);
        @(posedge clk);
        virt_addr <= row.va;
        trans_req <= 1'b1;
        @(posedge clk);
        while (trans_ack !== 1'b1)
        begin
            @(posedge clk);
        end
        check_results(row);
        for (int i = 0; i < int'(row.hold); i++)
        begin
            @(posedge clk);
            check_value("trans_ack during hold", 64'(trans_ack), 64'd1);
            check_results(row);
        end
        trans_req <= 1'b0;
        @(posedge clk);
        while (trans_ack !== 1'b0)
        begin
            @(posedge clk);
        end
    endtask

    // arbiter and memory responder
    always @(posedge clk)
    begin
        if (reset)
        begin
            abtr_grant  <= 1'b0;
            bus_respcyc <= 1'b0;
            grant_armed = 1'b0;
            resp_active = 1'b0;
            gap_prev    = 1'b0;
        end
        else
        begin
            if (bus_respcyc)
            begin
                check_value("bus_respack", 64'(bus_respack), 64'd1);
            end
            if (!abtr_req)
            begin
                abtr_grant  <= 1'b0;
                grant_armed = 1'b0;
            end
            else if (!abtr_grant)
            begin
                if (!grant_armed)
                begin
                    grant_wait  = rand_bits(3);  // 0 to 7 cycles
                    grant_armed = 1'b1;
                end
                if (grant_wait == 0)
                begin
                    abtr_grant <= 1'b1;
                end
                else
                begin
                    grant_wait = grant_wait - 1;
                end
            end
            bus_respcyc <= 1'b0;
            if (bus_reqcyc)
            begin
                check_value("bus_req_addr line offset", 64'(bus_req_addr[5:0]), 64'd0);
                resp_active = 1'b1;
                resp_idx    = 0;
                resp_base   = bus_req_addr;
                gap_prev    = 1'b0;
            end
            if (resp_active)
            begin
                if (!gap_prev && lfsr_bit())
                begin
                    gap_prev = 1'b1;
                end
                else
                begin
                    gap_prev    = 1'b0;
                    bus_respcyc <= 1'b1;
                    bus_resp    <= read_word(resp_base + pa_width'(resp_idx * 8));
                    resp_idx    = resp_idx + 1;
                    if (resp_idx == 8)
                    begin
                        resp_active = 1'b0;
                    end
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: a page table walk hung after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    initial
    begin
        int hold_total;
        clk         = 1'b0;
        reset       = 1'b1;
        trans_req   = 1'b0;
        virt_addr   = '0;
        root_ppn    = root_tbl;
        abtr_grant  = 1'b0;
        bus_respcyc = 1'b0;
        bus_resp    = '0;
        lfsr        = 32'h1f44;
        hold_total  = 0;
        load_page_tables();
        load_rows();
        foreach (rows[i])
        begin
            hold_total = hold_total + int'(rows[i].hold);
        end
        timeout_cycles = rows.size() * levels * (8 + 8 + 8 + 6) * 2 + hold_total + 50;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i])
        begin
            run_row(rows[i]);
        end
        repeat (2) @(posedge clk);
        if (ptw_top_inst.ptw_props_inst.fail_count == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("bus or handshake assertions failed %0d times",
                     ptw_top_inst.ptw_props_inst.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: ptw_top.f
hdl/ptw_pkg.sv
hdl/pte_decode.sv
hdl/ptw_walk_ctrl.sv
hdl/ptw_result.sv
hdl/ptw_top.sv
tests/ptw_props.sv
tests/tb_ptw_top.sv

// File: build_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_ptw_top -f ptw_top.f -o tb_ptw_top; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ptw_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
